// File: source/aux_audio_pkg.sv
// Auxiliary audio path constants and the memory word type shared by all blocks
package aux_audio_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Timing and sizes
  ////////////////////////////////////////////////////////////////////////////

  // clk_114 cycles per stereo sample
  localparam int sample_period = 2572;

  localparam int burst_len = 4;          // Words per memory burst

  // Sample FIFO
  localparam int fifo_depth = 16;
  localparam int fifo_aw    = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Addressing
  ////////////////////////////////////////////////////////////////////////////

  localparam int stream_aw = 16;         // Word offset inside the region
  localparam int mem_aw    = 23;         // Memory word address

  // Upper address bits of the sample region
  localparam logic [mem_aw-stream_aw-1:0] stream_region = 7'b1101111;

  ////////////////////////////////////////////////////////////////////////////
  // DAC
  ////////////////////////////////////////////////////////////////////////////

  localparam int chip_aw = 24;           // Chipset mixer output width
  localparam int dac_w   = 16;           // Offset-binary code width

  // Memory word seen either as two bytes or as one sample
  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } byte_pair_t;

  typedef union packed {
    byte_pair_t  bytes;
    logic [15:0] word;
  } ram_word_u;

endpackage

// File: source/audio_stream_fetch.sv
// Audio stream fetch engine, issues burst reads and tracks outstanding fills
`timescale 1ns/1ps

module audio_stream_fetch
  import aux_audio_pkg::*;
(
  input  logic              clk_114,
  input  logic              reset,
  input  logic              enable,
  input  logic              mem_ack,
  input  logic              mem_fill,
  input  logic [fifo_aw:0]  fifo_count,
  output logic              mem_req,
  output logic [mem_aw-1:0] mem_addr
);

  logic [stream_aw-1:0] offset;       // Word offset of the next burst
  logic [fifo_aw:0]     fills_due;    // Words still to come for this burst
  logic [fifo_aw:0]     committed;    // FIFO words plus words in flight
  logic                 has_room;
  logic                 idle;

  ////////////////////////////////////////////////////////////////////////////
  // Room check
  ////////////////////////////////////////////////////////////////////////////

  assign committed = fifo_count + fills_due;
  assign has_room  = committed <= (fifo_aw + 1)'(fifo_depth - burst_len);

  // One burst at a time, so the next one waits for the last fill
  assign idle = !mem_req && (fills_due == '0);

  assign mem_addr = {stream_region, offset};

  ////////////////////////////////////////////////////////////////////////////
  // Request and fill tracking
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_114) begin
    if (reset || !enable) begin
      // Disabled stream restarts from the region base
      offset    <= '0;
      mem_req   <= 1'b0;
      fills_due <= '0;
    end else begin
      if (mem_req) begin
        if (mem_ack) begin
          mem_req   <= 1'b0;
          fills_due <= (fifo_aw + 1)'(burst_len);
          offset    <= offset + stream_aw'(burst_len);  // Wraps at 64K words
        end
      end else if (idle && has_room) begin
        mem_req <= 1'b1;
      end

      // Fills only follow an ack, never in the same cycle
      if (mem_fill && (fills_due != '0)) begin
        fills_due <= fills_due - 1'b1;
      end
    end
  end

endmodule

// File: source/sample_fifo.sv
// Show-ahead sample FIFO between the memory fills and the sample pacer
`timescale 1ns/1ps

module sample_fifo
  import aux_audio_pkg::*;
(
  input  logic             clk_114,
  input  logic             reset,
  input  logic             flush,
  input  logic             wr,
  input  ram_word_u        wr_data,
  input  logic             pop,
  output ram_word_u        head,
  output logic             empty,
  output logic [fifo_aw:0] count
);

  ram_word_u          mem [fifo_depth];   // Payload only, no reset
  logic [fifo_aw-1:0] wr_ptr;
  logic [fifo_aw-1:0] rd_ptr;
  logic               do_rd;

  assign empty = (count == '0);
  assign do_rd = pop && !empty;
  assign head  = mem[rd_ptr];            // Head word readable without a pop

  always_ff @(posedge clk_114) begin
    if (wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_114) begin
    if (reset || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;         // Both or neither
      endcase
    end
  end

endmodule

// File: source/aux_sample_pacer.sv
// Auxiliary sample pacer, pops left and right words once per sample period
`timescale 1ns/1ps

module aux_sample_pacer
  import aux_audio_pkg::*;
(
  input  logic        clk_114,
  input  logic        reset,
  input  logic        enable,
  input  ram_word_u   head,
  input  logic        empty,
  output logic        pop,
  output logic [15:0] aux_left,
  output logic [15:0] aux_right
);

  logic [$clog2(sample_period)-1:0] period_cnt;
  logic                             period_end;
  logic                             left_slot;
  logic                             right_slot;
  ram_word_u                        swapped;

  ////////////////////////////////////////////////////////////////////////////
  // Sample period
  ////////////////////////////////////////////////////////////////////////////

  assign period_end = period_cnt == $bits(period_cnt)'(sample_period - 1);
  assign left_slot  = period_cnt == '0;
  assign right_slot = period_cnt == $bits(period_cnt)'(1);

  // A missing word skips the pop and keeps the old sample
  assign pop = enable && !empty && (left_slot || right_slot);

  // Memory keeps samples in the other byte order
  always_comb begin
    swapped.bytes.hi = head.bytes.lo;
    swapped.bytes.lo = head.bytes.hi;
  end

  always_ff @(posedge clk_114) begin
    if (reset) begin
      period_cnt <= '0;
      aux_left   <= '0;
      aux_right  <= '0;
    end else begin
      if (!enable || period_end) begin
        period_cnt <= '0;
      end else begin
        period_cnt <= period_cnt + 1'b1;
      end

      if (pop && left_slot) begin
        aux_left <= swapped.word;          // First word of the pair
      end
      if (pop && right_slot) begin
        aux_right <= swapped.word;
      end
    end
  end

endmodule

// File: source/sigma_delta_dac.sv
// Stereo audio DAC, offset-binary conversion and first-order sigma-delta
`timescale 1ns/1ps

module sigma_delta_dac
  import aux_audio_pkg::*;
(
  input  logic               clk_114,
  input  logic               reset,
  input  logic [chip_aw-1:0] chip_left,
  input  logic [chip_aw-1:0] chip_right,
  output logic               audio_l,
  output logic               audio_r
);

  logic [chip_aw-1:0] chip_in [2];

  assign chip_in[0] = chip_left;
  assign chip_in[1] = chip_right;

  ////////////////////////////////////////////////////////////////////////////
  // One modulator per channel
  ////////////////////////////////////////////////////////////////////////////

  for (genvar ch = 0; ch < 2; ch++) begin : g_chan
    logic [dac_w-1:0] code;
    logic [dac_w-1:0] acc;
    logic [dac_w:0]   sum;
    logic             out_bit;

    // Flip the sign and keep the top bits below it
    assign code = {~chip_in[ch][chip_aw-1], chip_in[ch][chip_aw-2 -: dac_w-1]};
    assign sum  = {1'b0, acc} + {1'b0, code};

    // Carry density over 64K cycles is the code
    always_ff @(posedge clk_114) begin
      if (reset) begin
        acc     <= '0;
        out_bit <= 1'b0;
      end else begin
        acc     <= sum[dac_w-1:0];
        out_bit <= sum[dac_w];
      end
    end
  end

  assign audio_l = g_chan[0].out_bit;
  assign audio_r = g_chan[1].out_bit;

endmodule

// File: source/aux_audio_top.sv
// Auxiliary audio top level, stream fetch, sample FIFO, pacer and audio DAC
`timescale 1ns/1ps

module aux_audio_top
  import aux_audio_pkg::*;
(
  input  logic               clk_114,
  input  logic               reset,
  input  logic               enable,
  // Memory side
  input  logic               mem_ack,
  input  logic               mem_fill,
  input  logic [15:0]        mem_data,
  output logic               mem_req,
  output logic [mem_aw-1:0]  mem_addr,
  // Chipset mixer
  input  logic [chip_aw-1:0] chip_left,
  input  logic [chip_aw-1:0] chip_right,
  output logic [15:0]        aux_left,
  output logic [15:0]        aux_right,
  // DAC outputs
  output logic               audio_l,
  output logic               audio_r
);

  logic             fifo_flush;
  logic [fifo_aw:0] fifo_count;
  logic             fifo_empty;
  ram_word_u        fifo_head;
  logic             sample_pop;

  assign fifo_flush = ~enable;         // Drop stale words while stopped

  ////////////////////////////////////////////////////////////////////////////
  // Auxiliary stream
  ////////////////////////////////////////////////////////////////////////////

  audio_stream_fetch u_audio_stream_fetch (
    .clk_114    (clk_114),
    .reset      (reset),
    .enable     (enable),
    .mem_ack    (mem_ack),
    .mem_fill   (mem_fill),
    .fifo_count (fifo_count),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr)
  );

  sample_fifo u_sample_fifo (
    .clk_114 (clk_114),
    .reset   (reset),
    .flush   (fifo_flush),
    .wr      (mem_fill),
    .wr_data (mem_data),
    .pop     (sample_pop),
    .head    (fifo_head),
    .empty   (fifo_empty),
    .count   (fifo_count)
  );

  aux_sample_pacer u_aux_sample_pacer (
    .clk_114   (clk_114),
    .reset     (reset),
    .enable    (enable),
    .head      (fifo_head),
    .empty     (fifo_empty),
    .pop       (sample_pop),
    .aux_left  (aux_left),
    .aux_right (aux_right)
  );

  // Chipset audio DAC
  sigma_delta_dac u_sigma_delta_dac (
    .clk_114    (clk_114),
    .reset      (reset),
    .chip_left  (chip_left),
    .chip_right (chip_right),
    .audio_l    (audio_l),
    .audio_r    (audio_r)
  );

endmodule

// File: sim/tb_aux_audio_asserts.sv
// Fetch handshake assertions bound into the audio stream fetch engine
`timescale 1ns/1ps

module tb_aux_audio_asserts
  import aux_audio_pkg::*;
(
  input logic              clk_114,
  input logic              reset,
  input logic              enable,
  input logic              mem_req,
  input logic              mem_ack,
  input logic              mem_fill,
  input logic [mem_aw-1:0] mem_addr,
  input logic [fifo_aw:0]  fills_due,
  input logic [fifo_aw:0]  fifo_count
);

  int fail_count = 0;                    // Assertion failures so far

  // Request waits with a fixed address until the memory takes it
  req_hold: assert property (@(posedge clk_114) disable iff (reset)
    mem_req && !mem_ack && enable |=> mem_req && $stable(mem_addr))
    else begin
      $error("mem_req dropped or mem_addr moved before mem_ack");
      fail_count++;
    end

  fill_owned: assert property (@(posedge clk_114) disable iff (reset)
    mem_fill && enable |-> fills_due != '0)
    else begin
      $error("mem_fill arrived with no burst outstanding");
      fail_count++;
    end

  req_after_reset: assert property (@(posedge clk_114)
    reset |=> !mem_req)
    else begin
      $error("mem_req high in the cycle after reset");
      fail_count++;
    end

  // Room is reserved before each request
  no_overflow: assert property (@(posedge clk_114) disable iff (reset)
    fifo_count + fills_due <= (fifo_aw + 1)'(fifo_depth))
    else begin
      $error("FIFO words plus fills due exceed the FIFO depth");
      fail_count++;
    end

endmodule

bind audio_stream_fetch tb_aux_audio_asserts u_fetch_asserts (
  .clk_114    (clk_114),
  .reset      (reset),
  .enable     (enable),
  .mem_req    (mem_req),
  .mem_ack    (mem_ack),
  .mem_fill   (mem_fill),
  .mem_addr   (mem_addr),
  .fills_due  (fills_due),
  .fifo_count (fifo_count)
);

// File: sim/tb_aux_audio_top.sv
// Testbench for the auxiliary audio path with memory model, stream and DAC checks
`timescale 1ns/1ps

module tb_aux_audio_top
  import aux_audio_pkg::*;
();

  localparam int clk_period     = 20;
  localparam int drive_delay    = 2;
  localparam int sample_delay   = 5;
  localparam int reset_cycles   = 16;
  localparam int dac_window     = 4096;
  localparam int expected_pairs = 13;     // Twelve in the long run plus one after restart
  // Covers 14 sample periods, two DAC windows and the resets with margin
  localparam int timeout_cycles = 60000;

  typedef enum int {mem_idle, mem_wait_ack, mem_filling} mem_state_t;

  logic               clk_114;
  logic               reset;
  logic               enable;
  logic               mem_ack  = 1'b0;
  logic               mem_fill = 1'b0;
  logic [15:0]        mem_data = '0;
  logic [chip_aw-1:0] chip_left;
  logic [chip_aw-1:0] chip_right;
  logic               mem_req;
  logic [mem_aw-1:0]  mem_addr;
  logic [15:0]        aux_left;
  logic [15:0]        aux_right;
  logic               audio_l;
  logic               audio_r;

  logic [31:0]          mem_rng  = 32'hc175fab6;
  logic [31:0]          stim_rng = 32'hc175fab6;
  mem_state_t           mem_state = mem_idle;
  int                   ack_max = 0;      // Memory delay ranges
  int                   gap_max = 0;
  int                   mem_wait;
  int                   mem_gap;
  int                   fills_left;
  logic [stream_aw-1:0] burst_off;
  logic                 req_seen;
  logic                 run_seen;
  int                   cycles = 0;
  int                   edge_idx = -1;    // Edges since enable was sampled high
  int                   acks_seen = 0;
  int                   pairs_checked = 0;
  int                   pair;
  logic [15:0]          held_left;
  logic [15:0]          held_right;
  int                   ones_l;
  int                   ones_r;

  aux_audio_top u_aux_audio_top (
    .clk_114    (clk_114),
    .reset      (reset),
    .enable     (enable),
    .mem_ack    (mem_ack),
    .mem_fill   (mem_fill),
    .mem_data   (mem_data),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .chip_left  (chip_left),
    .chip_right (chip_right),
    .aux_left   (aux_left),
    .aux_right  (aux_right),
    .audio_l    (audio_l),
    .audio_r    (audio_r)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Word the memory holds at a stream offset
  function automatic logic [15:0] stream_word(input logic [stream_aw-1:0] off);
    logic [15:0] mix;
    mix = off * 16'h9e37;
    return mix ^ {off[7:0], off[15:8]} ^ 16'h3c5a;
  endfunction

  // Aux sample for the n-th word popped since enable rose
  function automatic logic [15:0] expected_aux(input int pop_index);
    logic [15:0] w;
    w = stream_word(stream_aw'(pop_index));
    return {w[7:0], w[15:8]};             // Memory byte order to sample order
  endfunction

  // Signed chipset value moved up by half scale with the top bits kept
  function automatic logic [dac_w-1:0] expected_code(input logic [chip_aw-1:0] chip);
    logic [chip_aw-1:0] biased;
    biased = chip + 24'h800000;
    return biased[chip_aw-1 -: dac_w];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic end_with_failure();
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_level(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, actual, expected);
      end_with_failure();
    end
  endtask

  task automatic check_sample(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, actual, expected);
      end_with_failure();
    end
  endtask

  task automatic check_addr(input string name, input logic [mem_aw-1:0] actual,
                            input logic [mem_aw-1:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, actual, expected);
      end_with_failure();
    end
  endtask

  // Ones in the window may differ from the code share by one
  task automatic check_count(input string name, input int ones, input logic [dac_w-1:0] code);
    int scaled;
    int share;
    scaled = ones * (65536 / dac_window);
    share  = 65536 / dac_window;
    if (scaled > int'(code) + share || scaled < int'(code) - share) begin
      $display("MISMATCH at %0t: %s got %0d ones expected %0d", $time, name, ones,
               int'(code) / share);
      end_with_failure();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Clock, timeout and memory model
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk_114 = 1'b0;
    forever #(clk_period / 2) clk_114 = ~clk_114;
  end

  always @(posedge clk_114) begin
    cycles = cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("Run did not finish within %0d cycles", timeout_cycles);
      end_with_failure();
    end else if (u_aux_audio_top.u_audio_stream_fetch.u_fetch_asserts.fail_count != 0) begin
      $display("A fetch handshake assertion failed");
      end_with_failure();
    end
  end

  always @(posedge clk_114) begin
    req_seen = mem_req;                   // Values the DUT saw at this edge
    run_seen = enable && !reset;
    #(drive_delay);
    mem_ack  = 1'b0;
    mem_fill = 1'b0;
    if (!run_seen) begin
      mem_state = mem_idle;               // Outstanding burst dropped
    end else begin
      if (mem_state == mem_idle && req_seen) begin
        mem_rng   = xorshift32(mem_rng);
        mem_wait  = int'(mem_rng % 32'(ack_max + 1));
        mem_state = mem_wait_ack;
      end
      if (mem_state == mem_wait_ack) begin
        if (mem_wait == 0) begin
          mem_ack    = 1'b1;
          burst_off  = mem_addr[stream_aw-1:0];
          fills_left = burst_len;
          mem_rng    = xorshift32(mem_rng);
          mem_gap    = int'(mem_rng % 32'(gap_max + 1));
          mem_state  = mem_filling;
        end else begin
          mem_wait = mem_wait - 1;
        end
      end else if (mem_state == mem_filling) begin
        if (mem_gap == 0) begin
          mem_fill   = 1'b1;
          mem_data   = stream_word(burst_off);
          burst_off  = burst_off + stream_aw'(1);
          fills_left = fills_left - 1;
          mem_rng    = xorshift32(mem_rng);
          mem_gap    = int'(mem_rng % 32'(gap_max + 1));
          if (fills_left == 0) begin
            mem_state = mem_idle;
          end
        end else begin
          mem_gap = mem_gap - 1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_114) begin
    if (reset || !enable) begin
      edge_idx  = -1;
      acks_seen = 0;
    end else begin
      edge_idx = edge_idx + 1;
    end
    #(sample_delay);
    if (edge_idx < 0) begin
      held_left  = aux_left;              // Last values before enable rises
      held_right = aux_right;
    end else if (edge_idx < sample_period) begin
      check_sample("aux_left", aux_left, held_left);    // First period stays empty
      check_sample("aux_right", aux_right, held_right);
    end else if (edge_idx > sample_period && edge_idx % sample_period == 1) begin
      pair = edge_idx / sample_period - 1;
      check_sample("aux_left", aux_left, expected_aux(2 * pair));
      check_sample("aux_right", aux_right, expected_aux(2 * pair + 1));
      pairs_checked = pairs_checked + 1;
    end
    if (enable && mem_req && mem_ack) begin
      check_addr("mem_addr", mem_addr, {stream_region, stream_aw'(acks_seen * burst_len)});
      acks_seen = acks_seen + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    reset      = 1'b1;
    enable     = 1'b0;
    chip_left  = '0;
    chip_right = '0;
    stim_rng   = xorshift32(stim_rng);   // Own sequence apart from the memory
    repeat (reset_cycles) @(posedge clk_114);
    #(drive_delay);
    reset = 1'b0;
    #(sample_delay - drive_delay);
    check_level("mem_req", mem_req, 1'b0);
    check_level("audio_l", audio_l, 1'b0);
    check_level("audio_r", audio_r, 1'b0);
    check_sample("aux_left", aux_left, '0);
    check_sample("aux_right", aux_right, '0);

    // Prompt memory first, then stretched ack and fill delays
    @(posedge clk_114);
    #(drive_delay);
    enable = 1'b1;
    repeat (3 * sample_period) @(posedge clk_114);
    ack_max = 5;
    gap_max = 3;
    repeat (10 * sample_period) @(posedge clk_114);

    // Restart from offset 0
    #(drive_delay);
    enable = 1'b0;
    repeat (5) @(posedge clk_114);
    #(drive_delay);
    enable = 1'b1;
    repeat (sample_period + 8) @(posedge clk_114);
    #(drive_delay);
    enable = 1'b0;

    repeat (2) begin
      @(posedge clk_114);
      #(drive_delay);
      stim_rng   = xorshift32(stim_rng);
      chip_left  = stim_rng[chip_aw-1:0];
      stim_rng   = xorshift32(stim_rng);
      chip_right = stim_rng[chip_aw-1:0];
      repeat (4) @(posedge clk_114);
      ones_l = 0;
      ones_r = 0;
      repeat (dac_window) begin
        @(posedge clk_114);
        #(sample_delay);
        ones_l = ones_l + int'(audio_l);
        ones_r = ones_r + int'(audio_r);
      end
      check_count("audio_l", ones_l, expected_code(chip_left));
      check_count("audio_r", ones_r, expected_code(chip_right));
    end

    if (pairs_checked != expected_pairs) begin
      $display("Only %0d of %0d sample pairs were checked", pairs_checked, expected_pairs);
      end_with_failure();
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

// File: sim.f
source/aux_audio_pkg.sv
source/audio_stream_fetch.sv
source/sample_fifo.sv
source/aux_sample_pacer.sv
source/sigma_delta_dac.sv
source/aux_audio_top.sv
sim/tb_aux_audio_asserts.sv
sim/tb_aux_audio_top.sv

// File: Makefile
# Verilator build and run of the auxiliary audio testbench

VERILATOR ?= verilator
TOP       ?= tb_aux_audio_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?=

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)
